// File: vlog.f
+incdir+hw
hw/fifo_pkg.sv
hw/handshake_pkg.sv
hw/sram_1r1w.sv
hw/sync_fifo.sv
hw/req_ack_ingress.sv
hw/req_ack_egress.sv
hw/fifo_channel.sv
dv/fifo_channel_chk.sv
dv/fifo_channel_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the channel testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module fifo_channel_tb -Mdir obj_dir -f vlog.f \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/Vfifo_channel_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -qx "Result: PASSED" sim.log && echo "Simulation passed" \
	|| { echo "Simulation did not pass"; exit 1; }

// File: dv/fifo_channel_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "channel_cfg.svh"

// Testbench for the buffered word channel
// Random four-phase agents on both ports, a queue model of accepted words and a watchdog
module fifo_channel_tb import fifo_pkg::*;
();

	localparam int ORDER_WORDS = 300;
	localparam int AFTER_FLUSH_WORDS = 40;
	// The fill phase puts CH_DEPTH words in the FIFO, one in egress and leaves one pending
	localparam int PLANNED_WORDS = ORDER_WORDS + `CH_DEPTH + 2 + AFTER_FLUSH_WORDS;
	// Worst case clocks per handshake, random gaps and quiet waits included
	localparam int HANDSHAKE_CLKS = 60;
	localparam int TIMEOUT_NS = PLANNED_WORDS * HANDSHAKE_CLKS * 8;

	logic clk;
	logic reset;
	logic flush;
	logic in_req;
	data_word_t in_data;
	logic in_ack;
	logic out_req;
	data_word_t out_data;
	logic out_ack;
	fifo_status_t status;

	// Words accepted upstream and not yet offered downstream
	data_word_t model_q[$];
	// Set while egress offers a word taken from the model
	logic held_valid;
	int unsigned up_left;
	logic dn_stall;
	string test_name;
	int unsigned mismatches = 0;
	int unsigned other_errors = 0;
	int unsigned pushed = 0;
	int unsigned delivered = 0;
	int unsigned flushed = 0;
	logic in_ack_q;
	logic out_req_q;
	logic [3:0] ports_q;
	int unsigned stable_clks;

	fifo_channel dut (
		.clk(clk),
		.reset(reset),
		.flush_i(flush),
		.in_req_i(in_req),
		.in_data_i(in_data),
		.in_ack_o(in_ack),
		.out_req_o(out_req),
		.out_data_o(out_data),
		.out_ack_i(out_ack),
		.status_o(status)
	);

	bind fifo_channel fifo_channel_chk chk (
		.clk(clk),
		.reset(reset),
		.in_req_i(in_req_i),
		.in_ack_i(in_ack_o),
		.out_req_i(out_req_o),
		.out_data_i(out_data_o),
		.status_i(status_o),
		.enqueue_i(enqueue)
	);

	// Flags that the threshold rules give for a FIFO occupancy
	function automatic fifo_status_t expected_status(int count);
		fifo_status_t s;
		s.full = count == `CH_DEPTH;
		s.almost_full = count >= `CH_DEPTH - `CH_AF_THRESH;
		s.empty = count == 0;
		s.almost_empty = count <= `CH_AE_THRESH;
		return s;
	endfunction

	task automatic report_mismatch(string what, logic [31:0] expected, logic [31:0] actual);
		mismatches++;
		$display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
	endtask

	task automatic report_error(string what);
		other_errors++;
		$display("ERROR %s: %s", test_name, what);
	endtask

	// Upstream requester, one word per four-phase cycle with random gaps
	task automatic drive_upstream();
		if (!in_req && !in_ack && up_left != 0)
		begin
			if ($urandom_range(3) == 0)
			begin
				in_data <= data_word_t'($urandom);
				in_req <= 1'b1;
			end
		end
		else if (in_req && in_ack)
		begin
			if ($urandom_range(2) == 0)
			begin
				in_req <= 1'b0;
				up_left--;
			end
		end
	endtask

	// Downstream responder, ack is withheld entirely while stalled
	task automatic drive_downstream();
		if (out_req && !out_ack)
		begin
			if (!dn_stall && $urandom_range(3) == 0)
				out_ack <= 1'b1;
		end
		else if (!out_req && out_ack)
		begin
			if ($urandom_range(2) == 0)
				out_ack <= 1'b0;
		end
	endtask

	// Waits until everything sent has been delivered and the ports are idle
	task automatic wait_drained();
		while (up_left != 0 || in_req || in_ack || out_req || out_ack || model_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		if (status !== expected_status(0))
			report_mismatch("drained status", expected_status(0), status);
	endtask

	// Sends single words with the downstream side stalled until ack stays low
	task automatic fill_until_stalled();
		int idle_clks;
		idle_clks = 0;
		while (idle_clks < 20)
		begin
			if (up_left == 0 && !in_req && !in_ack)
			begin
				// Quiet gap so the monitor compares the flags at every occupancy
				repeat (4) @(negedge clk);
				up_left = 1;
			end
			@(negedge clk);
			if (in_req && !in_ack)
				idle_clks++;
			else
				idle_clks = 0;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Both agents share one process so that every draw comes from the seeded generator
	initial
	begin
		void'($urandom(32'h139c_ca9a));
		forever
		begin
			@(posedge clk);
			if (!reset)
			begin
				drive_upstream();
				drive_downstream();
			end
		end
	end

	// Monitor on the falling edge, where all DUT outputs have settled
	always @(negedge clk)
	begin
		if (reset)
		begin
			held_valid = 1'b0;
			in_ack_q = 1'b0;
			out_req_q = 1'b0;
			ports_q = '0;
			stable_clks = 0;
		end
		else
		begin
			// Data is still held by the requester when ack is first seen
			if (in_ack && !in_ack_q)
			begin
				model_q.push_back(in_data);
				pushed++;
			end
			if (out_req && !out_req_q)
			begin
				if (model_q.size() == 0)
					report_error("downstream offered a word with nothing outstanding");
				else if (out_data !== model_q[0])
					report_mismatch("word", model_q[0], out_data);
				if (model_q.size() != 0)
					void'(model_q.pop_front());
				held_valid = 1'b1;
			end
			if (!out_req && out_req_q)
			begin
				held_valid = 1'b0;
				delivered++;
			end
			// Flush drops queued words, the egress word stays in flight
			if (flush)
			begin
				flushed += model_q.size();
				model_q.delete();
			end
			// After three clocks without handshake activity the flags must have settled
			if ({in_req, in_ack, out_req, out_ack} != ports_q || flush)
				stable_clks = 0;
			else if (stable_clks < 4)
				stable_clks++;
			if (stable_clks == 3 && status !== expected_status(model_q.size()))
				report_mismatch("quiet status", expected_status(model_q.size()), status);
			in_ack_q = in_ack;
			out_req_q = out_req;
			ports_q = {in_req, in_ack, out_req, out_ack};
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog expired at %0t ns with %0d words still to send", $time, up_left);
		$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		flush = 1'b0;
		in_req = 1'b0;
		in_data = '0;
		out_ack = 1'b0;
		up_left = 0;
		dn_stall = 1'b0;
		test_name = "reset";
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (in_ack !== 1'b0 || out_req !== 1'b0)
			report_error("a handshake output is high right after reset");
		if (status !== expected_status(0))
			report_mismatch("status", expected_status(0), status);

		test_name = "order";
		up_left = ORDER_WORDS;
		wait_drained();

		// Downstream stalled, the FIFO fills and the requester is held off
		test_name = "backpressure";
		dn_stall = 1'b1;
		fill_until_stalled();
		if (model_q.size() + held_valid != `CH_DEPTH + 1)
			report_mismatch("words in flight", `CH_DEPTH + 1, model_q.size() + held_valid);
		if (status !== expected_status(`CH_DEPTH))
			report_mismatch("status", expected_status(`CH_DEPTH), status);

		// Flush with a word held by egress and one word pending upstream
		test_name = "flush";
		if (!held_valid)
			report_error("egress held no word before the flush");
		@(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		@(negedge clk);
		if (status !== expected_status(0))
			report_mismatch("status", expected_status(0), status);
		dn_stall = 1'b0;
		up_left = up_left + AFTER_FLUSH_WORDS;
		wait_drained();

		if (delivered != pushed - flushed)
			report_mismatch("delivered count", pushed - flushed, delivered);
		$display("Run finished: %0d mismatches, %0d other errors, %0d assertion failures, %0d words",
			mismatches, other_errors, dut.chk.fail_count, delivered);
		if (mismatches == 0 && other_errors == 0 && dut.chk.fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/fifo_channel_chk.sv
`timescale 1ns/1ns
`default_nettype none

// Concurrent checks on the handshake ports and the FIFO flags of fifo_channel
module fifo_channel_chk import fifo_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic in_req_i,
	input wire logic in_ack_i,
	input wire logic out_req_i,
	input wire data_word_t out_data_i,
	input wire fifo_status_t status_i,
	input wire logic enqueue_i
);

	// Count of failed assertions
	int unsigned fail_count = 0;

	// The receiver may only acknowledge a request that is actually present
	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(in_ack_i) |-> in_req_i)
	else
	begin
		$error("in_ack rose while in_req was low");
		fail_count++;
	end

	// A word on offer must not change until the handshake has moved on
	out_data_held: assert property (@(posedge clk) disable iff (reset)
		out_req_i && $past(out_req_i) |-> $stable(out_data_i))
	else
	begin
		$error("out_data changed while out_req was high");
		fail_count++;
	end

	// Full and empty never come together, and each one implies its threshold flag
	// The threshold flags are tracked on their own, so this ties the two kinds together
	flags_consistent: assert property (@(posedge clk) disable iff (reset)
		!(status_i.empty && status_i.full)
		&& (!status_i.full || status_i.almost_full)
		&& (!status_i.empty || status_i.almost_empty))
	else
	begin
		$error("FIFO flags disagree with each other");
		fail_count++;
	end

	// Back-pressure must stop every write into a full FIFO
	no_write_when_full: assert property (@(posedge clk) disable iff (reset)
		enqueue_i |-> !status_i.full)
	else
	begin
		$error("enqueue while the FIFO is full");
		fail_count++;
	end

endmodule

`default_nettype wire

// File: hw/fifo_channel.sv
`timescale 1ns/1ns
`default_nettype none

// Buffered word channel
// Upstream req/ack port, FIFO, downstream req/ack port, all on one clock
module fifo_channel import fifo_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic flush_i,
	input wire logic in_req_i,
	input wire data_word_t in_data_i,
	output wire logic in_ack_o,
	output wire logic out_req_o,
	output wire data_word_t out_data_o,
	input wire logic out_ack_i,
	output wire fifo_status_t status_o
);

	// Ingress to FIFO
	logic enqueue;
	data_word_t enqueue_value;

	// FIFO to egress
	logic dequeue;
	data_word_t head_value;

	// Back-pressure comes from the registered full flag
	req_ack_ingress ingress (
		.clk(clk),
		.reset(reset),
		.req_i(in_req_i),
		.data_i(in_data_i),
		.ack_o(in_ack_o),
		.full_i(status_o.full),
		.enqueue_o(enqueue),
		.value_o(enqueue_value)
	);

	sync_fifo fifo (
		.clk(clk),
		.reset(reset),
		.flush_i(flush_i),
		.enqueue_i(enqueue),
		.value_i(enqueue_value),
		.dequeue_i(dequeue),
		.value_o(head_value),
		.status_o(status_o)
	);

	// The egress side only needs to know whether a head word is present
	req_ack_egress egress (
		.clk(clk),
		.reset(reset),
		.empty_i(status_o.empty),
		.value_i(head_value),
		.dequeue_o(dequeue),
		.req_o(out_req_o),
		.data_o(out_data_o),
		.ack_i(out_ack_i)
	);

endmodule

`default_nettype wire

// File: hw/req_ack_egress.sv
`timescale 1ns/1ns
`default_nettype none

// Four-phase sender on the downstream port
// Takes one word from the FIFO head and offers it until the handshake completes
module req_ack_egress import fifo_pkg::*, handshake_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic empty_i,
	input wire data_word_t value_i,
	output logic dequeue_o,
	output logic req_o,
	output data_word_t data_o,
	input wire logic ack_i
);

	egress_state_t state_ff;
	egress_state_t state_nxt;
	data_word_t hold_ff;

	always_comb
	begin
		state_nxt = state_ff;
		dequeue_o = 1'b0;
		case (state_ff)
			OUT_IDLE:
			begin
				// Words are only taken here, one per handshake
				if (!empty_i)
				begin
					dequeue_o = 1'b1;
					state_nxt = OUT_REQ;
				end
			end

			OUT_REQ:
			begin
				// Req drops one clock after ack is seen high
				if (ack_i)
					state_nxt = OUT_RELEASE;
			end

			OUT_RELEASE:
			begin
				// Wait for the responder to close the cycle
				if (!ack_i)
					state_nxt = OUT_IDLE;
			end

			default:
				state_nxt = OUT_IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			state_ff <= OUT_IDLE;
		else
			state_ff <= state_nxt;
	end

	// Hold register for the word on offer
	// Once captured, a flush or later enqueues cannot change what the
	// downstream side sees, and the word is still delivered after a flush
	always_ff @(posedge clk)
	begin
		if (dequeue_o)
			hold_ff <= value_i;
	end

	assign req_o = state_ff == OUT_REQ;
	assign data_o = hold_ff;

endmodule

`default_nettype wire

// File: hw/req_ack_ingress.sv
`timescale 1ns/1ns
`default_nettype none

// Four-phase receiver on the upstream port
// Accepts exactly one word per req/ack cycle and pushes it into the FIFO
module req_ack_ingress import fifo_pkg::*, handshake_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic req_i,
	input wire data_word_t data_i,
	output logic ack_o,
	input wire logic full_i,
	output logic enqueue_o,
	output data_word_t value_o
);

	ingress_state_t state_ff;
	ingress_state_t state_nxt;

	always_comb
	begin
		state_nxt = state_ff;
		enqueue_o = 1'b0;
		case (state_ff)
			IN_IDLE:
			begin
				// Ack is withheld while the FIFO is full, which stalls the requester
				if (req_i && !full_i)
				begin
					enqueue_o = 1'b1;
					state_nxt = IN_ACKED;
				end
			end

			IN_ACKED:
			begin
				// Ack falls one clock after req is seen low
				if (!req_i)
					state_nxt = IN_IDLE;
			end

			default:
				state_nxt = IN_IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			state_ff <= IN_IDLE;
		else
			state_ff <= state_nxt;
	end

	// The requester holds data stable until ack, so the enqueued word comes
	// straight from the port without a holding register
	assign value_o = data_i;
	assign ack_o = state_ff == IN_ACKED;

endmodule

`default_nettype wire

// File: hw/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "channel_cfg.svh"

// Circular-buffer FIFO with registered flags and a one-clock flush
// The head word on value_o is valid whenever the empty flag is low
module sync_fifo import fifo_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic flush_i,
	input wire logic enqueue_i,
	input wire data_word_t value_i,
	input wire logic dequeue_i,
	output data_word_t value_o,
	output fifo_status_t status_o
);

	localparam fifo_count_t DEPTH = fifo_count_t'(`CH_DEPTH);
	// Occupancy at or above which almost-full is set
	localparam fifo_count_t AF_LEVEL = fifo_count_t'(`CH_DEPTH - `CH_AF_THRESH);
	// Occupancy at or below which almost-empty is set
	localparam fifo_count_t AE_LEVEL = fifo_count_t'(`CH_AE_THRESH);
	localparam fifo_addr_t LAST_ADDR = fifo_addr_t'(`CH_DEPTH - 1);

	fifo_addr_t head_ff;
	fifo_addr_t head_nxt;
	fifo_addr_t tail_ff;
	fifo_addr_t tail_nxt;
	fifo_count_t count_ff;
	fifo_count_t count_nxt;
	fifo_status_t status_ff;
	logic almost_full_nxt;
	logic almost_empty_nxt;

	// The memory reads at the next head, so after a dequeue the following
	// word is already on value_o when the head pointer has moved
	sram_1r1w #(
		.DATA_WIDTH(`CH_DATA_WIDTH),
		.SIZE(`CH_DEPTH)
	) fifo_data (
		.clk(clk),
		.reset(reset),
		.rd_addr_i(head_nxt),
		.rd_data_o(value_o),
		.wr_en_i(enqueue_i),
		.wr_addr_i(tail_ff),
		.wr_data_i(value_i)
	);

	always_comb
	begin
		head_nxt = head_ff;
		tail_nxt = tail_ff;
		count_nxt = count_ff;
		almost_full_nxt = status_ff.almost_full;
		almost_empty_nxt = status_ff.almost_empty;

		if (flush_i)
		begin
			// Flush drops every stored word and wins over a same-cycle enqueue
			head_nxt = '0;
			tail_nxt = '0;
			count_nxt = '0;
			almost_full_nxt = 1'b0;
			almost_empty_nxt = 1'b1;
		end
		else
		begin
			// Both pointers wrap at the last entry
			if (enqueue_i)
				tail_nxt = (tail_ff == LAST_ADDR) ? '0 : tail_ff + 1'b1;

			if (dequeue_i)
				head_nxt = (head_ff == LAST_ADDR) ? '0 : head_ff + 1'b1;

			// The count only moves when exactly one side is active
			// Threshold flags flip as the count crosses their level
			if (enqueue_i && !dequeue_i)
			begin
				count_nxt = count_ff + 1'b1;
				if (count_ff == AF_LEVEL - 1'b1)
					almost_full_nxt = 1'b1;

				if (count_ff == AE_LEVEL)
					almost_empty_nxt = 1'b0;
			end
			else if (dequeue_i && !enqueue_i)
			begin
				count_nxt = count_ff - 1'b1;
				if (count_ff == AF_LEVEL)
					almost_full_nxt = 1'b0;

				if (count_ff == AE_LEVEL + 1'b1)
					almost_empty_nxt = 1'b1;
			end
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			head_ff <= '0;
			tail_ff <= '0;
			count_ff <= '0;
			// An empty FIFO is also almost empty
			status_ff <= '{full: 1'b0, almost_full: 1'b0, empty: 1'b1, almost_empty: 1'b1};
		end
		else
		begin
			head_ff <= head_nxt;
			tail_ff <= tail_nxt;
			count_ff <= count_nxt;
			status_ff.full <= count_nxt == DEPTH;
			status_ff.almost_full <= almost_full_nxt;
			status_ff.empty <= count_nxt == '0;
			status_ff.almost_empty <= almost_empty_nxt;
		end
	end

	assign status_o = status_ff;

endmodule

`default_nettype wire

// File: hw/sram_1r1w.sv
`timescale 1ns/1ns
`default_nettype none

`include "channel_cfg.svh"

// Register-array memory with one read port and one write port
// The read is registered, so data appears the clock after the address
module sram_1r1w import fifo_pkg::*;
#(
	parameter int DATA_WIDTH = `CH_DATA_WIDTH,
	parameter int SIZE = `CH_DEPTH
)
(
	input wire logic clk,
	input wire logic reset,
	input wire fifo_addr_t rd_addr_i,
	output data_word_t rd_data_o,
	input wire logic wr_en_i,
	input wire fifo_addr_t wr_addr_i,
	input wire data_word_t wr_data_i
);

	logic [DATA_WIDTH-1:0] mem [SIZE];

	// Storage array, written on the clock edge when enabled
	always_ff @(posedge clk)
	begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// Registered read port
	// A write to the address being read forwards the new word, so a word
	// written into an empty FIFO is at the head one clock later
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rd_data_o <= '0;
		else if (wr_en_i && wr_addr_i == rd_addr_i)
			rd_data_o <= wr_data_i;
		else
			rd_data_o <= mem[rd_addr_i];
	end

endmodule

`default_nettype wire

// File: hw/handshake_pkg.sv
`default_nettype none

// Types that describe the two four-phase handshake ports
package handshake_pkg;

	// Upstream receiver
	// IN_ACKED holds ack high until the requester has dropped req
	typedef enum logic
	{
		IN_IDLE,
		IN_ACKED
	} ingress_state_t;

	// Downstream sender
	// OUT_REQ offers the held word, OUT_RELEASE waits for ack to fall again
	typedef enum logic [1:0]
	{
		OUT_IDLE,
		OUT_REQ,
		OUT_RELEASE
	} egress_state_t;

endpackage

`default_nettype wire

// File: hw/fifo_pkg.sv
`default_nettype none

`include "channel_cfg.svh"

// Types that describe the storage side of the channel
package fifo_pkg;

	// One word as it travels through the channel
	typedef logic [`CH_DATA_WIDTH-1:0] data_word_t;

	// Index of one entry in the FIFO memory
	typedef logic [`CH_ADDR_WIDTH-1:0] fifo_addr_t;

	// Occupancy of the FIFO
	// One extra bit so that a completely full FIFO can be told from an empty one
	typedef logic [`CH_ADDR_WIDTH:0] fifo_count_t;

	// Registered FIFO flags, exported to both state machines and the top level
	// Note that almost_full is also set whenever full is, and almost_empty whenever empty is
	typedef struct packed
	{
		logic full;
		logic almost_full;
		logic empty;
		logic almost_empty;
	} fifo_status_t;

endpackage

`default_nettype wire

// File: hw/channel_cfg.svh
`ifndef CHANNEL_CFG_SVH
`define CHANNEL_CFG_SVH

// Number of bits in one word carried from the upstream to the downstream port
`define CH_DATA_WIDTH 16

// Number of entries the FIFO can hold before it back-pressures the upstream port
`define CH_DEPTH 8

// Bits needed to index one FIFO entry
// Must stay consistent with CH_DEPTH, which is a power of two here
`define CH_ADDR_WIDTH 3

// Almost-full is set when the free slots drop to this many or fewer
// With a depth of 8 it comes on at an occupancy of 6
`define CH_AF_THRESH 2

// Almost-empty is set while the occupancy is at or below this level
`define CH_AE_THRESH 2

`endif
